//--- src/conv_in_pkg.sv
package conv_in_pkg;

  // widths of the configuration counts.
  parameter int BITS_KH     = 4;
  parameter int BITS_CIN    = 8;
  parameter int BITS_COLS   = 10;
  parameter int BITS_BLOCKS = 8;

  // field positions in the low bits of the configuration beat.
  parameter int CFG_KH_LSB     = 0;
  parameter int CFG_CIN_LSB    = CFG_KH_LSB + BITS_KH;
  parameter int CFG_COLS_LSB   = CFG_CIN_LSB + BITS_CIN;
  parameter int CFG_BLOCKS_LSB = CFG_COLS_LSB + BITS_COLS;
  parameter int CFG_IS_MAX_BIT = CFG_BLOCKS_LSB + BITS_BLOCKS;

  // tuser flag positions.
  parameter int I_IS_MAX          = 0;
  parameter int I_IS_1X1          = 1;
  parameter int I_IS_TOP_BLOCK    = 2;
  parameter int I_IS_BOTTOM_BLOCK = 3;
  parameter int I_IS_CIN_LAST     = 4;
  // row index sits above the flags.
  parameter int I_KERNEL_ROW      = 5;
  parameter int TUSER_WIDTH       = I_KERNEL_ROW + BITS_KH;

endpackage

//--- src/axis_skid.sv
`timescale 1ns/1ps

module axis_skid #(
  parameter type t_payload = logic
) (
  input  logic     aclk,
  input  logic     i_reset,
  input  logic     i_valid,
  output logic     o_ready,
  input  t_payload i_data,
  input  logic     i_last,
  output logic     o_valid,
  input  logic     i_ready,
  output t_payload o_data,
  output logic     o_last
);

  logic     skid_valid;
  t_payload skid_data;
  logic     skid_last;
  logic     load_out;

  // output register empty or draining this cycle.
  assign load_out = !o_valid || i_ready;
  // ready comes straight from a flop.
  assign o_ready = !skid_valid;

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_out) begin
      o_valid    <= skid_valid || i_valid;
      skid_valid <= 1'b0;
    end else if (i_valid && o_ready) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (load_out) begin
      // spare entry goes first to keep order.
      if (skid_valid) begin
        o_data <= skid_data;
        o_last <= skid_last;
      end else begin
        o_data <= i_data;
        o_last <= i_last;
      end
    end else if (i_valid && o_ready) begin
      skid_data <= i_data;
      skid_last <= i_last;
    end
  end

  a_hold_stable: assert property (@(posedge aclk) disable iff (i_reset)
    o_valid && !i_ready |=> o_valid && $stable(o_data) && $stable(o_last));

endmodule

//--- src/weights_config_decoder.sv
`timescale 1ns/1ps

module weights_config_decoder #(
  parameter int  WORD_WIDTH = 8,
  parameter int  CORES      = 2,
  parameter int  KW_MAX     = 3,
  parameter int  KH_MAX     = 3,
  parameter int  CIN_MAX    = 8,
  localparam int DEPTH      = KH_MAX * CIN_MAX,
  localparam int AW         = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int W_WIDTH    = CORES * KW_MAX * WORD_WIDTH
) (
  input  logic                                  aclk,
  input  logic                                  i_reset,
  input  logic                                  i_s_weights_valid,
  output logic                                  o_s_weights_ready,
  input  logic [W_WIDTH-1:0]                    i_s_weights_data,
  input  logic                                  i_s_weights_last,
  output logic                                  o_we,
  output logic [AW-1:0]                         o_waddr,
  output logic [W_WIDTH-1:0]                    o_wdata,
  output logic                                  o_loaded,
  output logic [conv_in_pkg::BITS_KH-1:0]       o_kh_1,
  output logic [conv_in_pkg::BITS_CIN-1:0]      o_cin_1,
  output logic [conv_in_pkg::BITS_COLS-1:0]     o_cols_1,
  output logic [conv_in_pkg::BITS_BLOCKS-1:0]   o_blocks_1,
  output logic                                  o_is_max,
  input  logic                                  i_release
);

  logic is_config;
  logic xfer;

  // no new packet until the sequencer has used the current one.
  assign o_s_weights_ready = !o_loaded;
  assign xfer = i_s_weights_valid && o_s_weights_ready;
  assign o_we = xfer && !is_config;
  assign o_wdata = i_s_weights_data;

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      is_config <= 1'b1;
      o_waddr   <= '0;
      o_loaded  <= 1'b0;
    end else if (xfer) begin
      if (i_s_weights_last) begin
        is_config <= 1'b1;
        o_waddr   <= '0;
        o_loaded  <= 1'b1;
      end else begin
        is_config <= 1'b0;
        // rows of one channel are contiguous.
        if (!is_config) o_waddr <= o_waddr + 1'b1;
      end
    end else if (i_release) begin
      o_loaded <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (xfer && is_config) begin
      o_kh_1     <= i_s_weights_data[conv_in_pkg::CFG_KH_LSB +: conv_in_pkg::BITS_KH];
      o_cin_1    <= i_s_weights_data[conv_in_pkg::CFG_CIN_LSB +: conv_in_pkg::BITS_CIN];
      o_cols_1   <= i_s_weights_data[conv_in_pkg::CFG_COLS_LSB +: conv_in_pkg::BITS_COLS];
      o_blocks_1 <= i_s_weights_data[conv_in_pkg::CFG_BLOCKS_LSB +: conv_in_pkg::BITS_BLOCKS];
      o_is_max   <= i_s_weights_data[conv_in_pkg::CFG_IS_MAX_BIT];
    end
  end

  // writes stay inside the region named by the latched configuration.
  a_waddr_range: assert property (@(posedge aclk) disable iff (i_reset)
    o_we |-> (int'(o_waddr) < DEPTH) &&
             (int'(o_waddr) < (int'(o_kh_1) + 1) * (int'(o_cin_1) + 1)));

endmodule

//--- src/weights_store.sv
`timescale 1ns/1ps

module weights_store #(
  parameter int  WORD_WIDTH = 8,
  parameter int  CORES      = 2,
  parameter int  KW_MAX     = 3,
  parameter int  DEPTH      = 24,
  localparam int AW         = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int W_WIDTH    = CORES * KW_MAX * WORD_WIDTH
) (
  input  logic               aclk,
  input  logic               i_we,
  input  logic [AW-1:0]      i_waddr,
  input  logic [W_WIDTH-1:0] i_wdata,
  input  logic [AW-1:0]      i_raddr,
  output logic [W_WIDTH-1:0] o_rdata
);

  // entry c * kh + r holds row r of channel c.
  logic [W_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge aclk) begin
    if (i_we) mem[i_waddr] <= i_wdata;
  end

  // registered read with one cycle of latency.
  always_ff @(posedge aclk) begin
    o_rdata <= mem[i_raddr];
  end

endmodule

//--- src/conv_in_sequencer.sv
`timescale 1ns/1ps

module conv_in_sequencer #(
  parameter int  WORD_WIDTH = 8,
  parameter int  UNITS      = 4,
  parameter int  CORES      = 2,
  parameter int  KW_MAX     = 3,
  parameter int  KH_MAX     = 3,
  parameter int  CIN_MAX    = 8,
  localparam int DEPTH      = KH_MAX * CIN_MAX,
  localparam int AW         = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int W_WIDTH    = CORES * KW_MAX * WORD_WIDTH
) (
  input  logic                                aclk,
  input  logic                                i_reset,
  input  logic                                i_pix_valid,
  output logic                                o_pix_ready,
  input  logic [UNITS*WORD_WIDTH-1:0]         i_pix_data,
  input  logic                                i_loaded,
  input  logic [conv_in_pkg::BITS_KH-1:0]     i_kh_1,
  input  logic [conv_in_pkg::BITS_CIN-1:0]    i_cin_1,
  input  logic [conv_in_pkg::BITS_COLS-1:0]   i_cols_1,
  input  logic [conv_in_pkg::BITS_BLOCKS-1:0] i_blocks_1,
  input  logic                                i_is_max,
  output logic [AW-1:0]                       o_raddr,
  input  logic [W_WIDTH-1:0]                  i_rdata,
  output logic                                o_release,
  output logic                                o_valid,
  input  logic                                i_ready,
  output logic [UNITS*WORD_WIDTH-1:0]         o_pixels,
  output logic [W_WIDTH-1:0]                  o_weights,
  output logic [conv_in_pkg::TUSER_WIDTH-1:0] o_user,
  output logic                                o_last
);

  logic [conv_in_pkg::BITS_KH-1:0]     r;
  logic [conv_in_pkg::BITS_CIN-1:0]    c;
  logic [conv_in_pkg::BITS_COLS-1:0]   x;
  logic [conv_in_pkg::BITS_BLOCKS-1:0] b;
  logic [AW-1:0]                       addr;
  logic [AW-1:0]                       addr_prev;
  logic                                done;
  logic                                can_issue;
  logic                                issue;
  logic                                last_r;
  logic                                last_c;
  logic                                last_x;
  logic                                last_b;
  logic                                final_beat;
  logic [conv_in_pkg::TUSER_WIDTH-1:0] user_d;

  assign last_r = r == i_kh_1;
  assign last_c = c == i_cin_1;
  assign last_x = x == i_cols_1;
  assign last_b = b == i_blocks_1;
  assign final_beat = last_r && last_c && last_x && last_b;

  // read only when the output register can take the beat next cycle.
  assign can_issue = i_loaded && !done && (!o_valid || i_ready);
  assign issue = can_issue && i_pix_valid;
  // pixel beat is popped with its last kernel row.
  assign o_pix_ready = can_issue && last_r;
  // a stalled beat keeps re-reading its own entry.
  assign o_raddr = issue ? addr : addr_prev;
  assign o_weights = i_rdata;
  assign o_release = o_valid && i_ready && o_last;

  always_comb begin
    user_d = '0;
    user_d[conv_in_pkg::I_IS_MAX] = i_is_max;
    user_d[conv_in_pkg::I_IS_1X1] = i_kh_1 == '0;
    user_d[conv_in_pkg::I_IS_TOP_BLOCK] = b == '0;
    user_d[conv_in_pkg::I_IS_BOTTOM_BLOCK] = last_b;
    user_d[conv_in_pkg::I_IS_CIN_LAST] = last_c;
    user_d[conv_in_pkg::I_KERNEL_ROW +: conv_in_pkg::BITS_KH] = r;
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      r       <= '0;
      c       <= '0;
      x       <= '0;
      b       <= '0;
      addr    <= '0;
      done    <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      if (issue) begin
        r    <= last_r ? '0 : r + 1'b1;
        addr <= (last_r && last_c) ? '0 : addr + 1'b1;
        if (last_r) begin
          c <= last_c ? '0 : c + 1'b1;
          if (last_c) begin
            x <= last_x ? '0 : x + 1'b1;
            if (last_x) b <= last_b ? '0 : b + 1'b1;
          end
        end
      end
      // hold off until the final beat has left.
      if (issue && final_beat) done <= 1'b1;
      else if (o_release) done <= 1'b0;
      if (issue) o_valid <= 1'b1;
      else if (i_ready) o_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (issue) begin
      addr_prev <= addr;
      o_pixels  <= i_pix_data;
      o_user    <= user_d;
      o_last    <= final_beat;
    end
  end

  a_no_valid_unloaded: assert property (@(posedge aclk) disable iff (i_reset)
    !i_loaded |-> !o_valid);

endmodule

//--- src/conv_in_pipe.sv
`timescale 1ns/1ps

module conv_in_pipe #(
  parameter int  WORD_WIDTH = 8,
  parameter int  UNITS      = 4,
  parameter int  CORES      = 2,
  parameter int  KW_MAX     = 3,
  parameter int  KH_MAX     = 3,
  parameter int  CIN_MAX    = 8,
  localparam int DEPTH      = KH_MAX * CIN_MAX,
  localparam int AW         = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int W_WIDTH    = CORES * KW_MAX * WORD_WIDTH
) (
  input  logic                                aclk,
  input  logic                                i_reset,
  input  logic                                i_s_pixels_valid,
  output logic                                o_s_pixels_ready,
  input  logic [UNITS*WORD_WIDTH-1:0]         i_s_pixels_data,
  input  logic                                i_s_pixels_last,
  input  logic                                i_s_weights_valid,
  output logic                                o_s_weights_ready,
  input  logic [W_WIDTH-1:0]                  i_s_weights_data,
  input  logic                                i_s_weights_last,
  output logic                                o_m_valid,
  input  logic                                i_m_ready,
  output logic [UNITS*WORD_WIDTH-1:0]         o_m_pixels,
  output logic [W_WIDTH-1:0]                  o_m_weights,
  output logic [conv_in_pkg::TUSER_WIDTH-1:0] o_m_user,
  output logic                                o_m_last
);

  typedef logic [UNITS*WORD_WIDTH-1:0] t_pixels;

  // joined beat handed to the convolution engine.
  typedef struct packed {
    logic [UNITS*WORD_WIDTH-1:0]         pixels;
    logic [W_WIDTH-1:0]                  weights;
    logic [conv_in_pkg::TUSER_WIDTH-1:0] user;
  } t_out_beat;

  t_pixels                             pix_data;
  logic                                pix_valid;
  logic                                pix_ready;
  logic                                we;
  logic [AW-1:0]                       waddr;
  logic [W_WIDTH-1:0]                  wdata;
  logic [AW-1:0]                       raddr;
  logic [W_WIDTH-1:0]                  rdata;
  logic                                loaded;
  logic [conv_in_pkg::BITS_KH-1:0]     kh_1;
  logic [conv_in_pkg::BITS_CIN-1:0]    cin_1;
  logic [conv_in_pkg::BITS_COLS-1:0]   cols_1;
  logic [conv_in_pkg::BITS_BLOCKS-1:0] blocks_1;
  logic                                is_max;
  logic                                seq_release;
  logic                                seq_valid;
  logic                                seq_ready;
  logic [UNITS*WORD_WIDTH-1:0]         seq_pixels;
  logic [W_WIDTH-1:0]                  seq_weights;
  logic [conv_in_pkg::TUSER_WIDTH-1:0] seq_user;
  logic                                seq_last;
  t_out_beat                           m_beat;

  axis_skid #(.t_payload(t_pixels)) pix_skid (
    .aclk(aclk), .i_reset(i_reset),
    .i_valid(i_s_pixels_valid), .o_ready(o_s_pixels_ready),
    .i_data(i_s_pixels_data), .i_last(i_s_pixels_last),
    .o_valid(pix_valid), .i_ready(pix_ready), .o_data(pix_data), .o_last()
  );

  weights_config_decoder #(
    .WORD_WIDTH(WORD_WIDTH), .CORES(CORES), .KW_MAX(KW_MAX),
    .KH_MAX(KH_MAX), .CIN_MAX(CIN_MAX)
  ) decoder (
    .aclk(aclk), .i_reset(i_reset),
    .i_s_weights_valid(i_s_weights_valid), .o_s_weights_ready(o_s_weights_ready),
    .i_s_weights_data(i_s_weights_data), .i_s_weights_last(i_s_weights_last),
    .o_we(we), .o_waddr(waddr), .o_wdata(wdata), .o_loaded(loaded),
    .o_kh_1(kh_1), .o_cin_1(cin_1), .o_cols_1(cols_1), .o_blocks_1(blocks_1),
    .o_is_max(is_max), .i_release(seq_release)
  );

  weights_store #(
    .WORD_WIDTH(WORD_WIDTH), .CORES(CORES), .KW_MAX(KW_MAX), .DEPTH(DEPTH)
  ) store (
    .aclk(aclk), .i_we(we), .i_waddr(waddr), .i_wdata(wdata),
    .i_raddr(raddr), .o_rdata(rdata)
  );

  conv_in_sequencer #(
    .WORD_WIDTH(WORD_WIDTH), .UNITS(UNITS), .CORES(CORES), .KW_MAX(KW_MAX),
    .KH_MAX(KH_MAX), .CIN_MAX(CIN_MAX)
  ) sequencer (
    .aclk(aclk), .i_reset(i_reset),
    .i_pix_valid(pix_valid), .o_pix_ready(pix_ready), .i_pix_data(pix_data),
    .i_loaded(loaded), .i_kh_1(kh_1), .i_cin_1(cin_1), .i_cols_1(cols_1),
    .i_blocks_1(blocks_1), .i_is_max(is_max),
    .o_raddr(raddr), .i_rdata(rdata), .o_release(seq_release),
    .o_valid(seq_valid), .i_ready(seq_ready), .o_pixels(seq_pixels),
    .o_weights(seq_weights), .o_user(seq_user), .o_last(seq_last)
  );

  axis_skid #(.t_payload(t_out_beat)) out_skid (
    .aclk(aclk), .i_reset(i_reset),
    .i_valid(seq_valid), .o_ready(seq_ready),
    .i_data({seq_pixels, seq_weights, seq_user}), .i_last(seq_last),
    .o_valid(o_m_valid), .i_ready(i_m_ready), .o_data(m_beat), .o_last(o_m_last)
  );

  assign o_m_pixels  = m_beat.pixels;
  assign o_m_weights = m_beat.weights;
  assign o_m_user    = m_beat.user;

endmodule

//--- tests/conv_in_pipe_tb.sv
`timescale 1ns/1ps

module conv_in_pipe_tb;

  localparam int WORD_WIDTH = 8;
  localparam int UNITS      = 4;
  localparam int CORES      = 2;
  localparam int KW_MAX     = 3;
  localparam int KH_MAX     = 3;
  localparam int CIN_MAX    = 4;
  localparam int PW         = UNITS * WORD_WIDTH;
  localparam int WW         = CORES * KW_MAX * WORD_WIDTH;
  localparam int UW         = conv_in_pkg::TUSER_WIDTH;
  localparam int KHB        = conv_in_pkg::BITS_KH;
  localparam int CINB       = conv_in_pkg::BITS_CIN;
  localparam int COLB       = conv_in_pkg::BITS_COLS;
  localparam int BLKB       = conv_in_pkg::BITS_BLOCKS;
  localparam int CLK_PERIOD = 40;
  localparam int TIMEOUT    = 5000;
  localparam int NUM_IMAGES = 3;

  logic          aclk = 1'b0;
  logic          i_reset;
  logic          i_s_pixels_valid;
  logic          o_s_pixels_ready;
  logic [PW-1:0] i_s_pixels_data;
  logic          i_s_pixels_last;
  logic          i_s_weights_valid;
  logic          o_s_weights_ready;
  logic [WW-1:0] i_s_weights_data;
  logic          i_s_weights_last;
  logic          o_m_valid;
  logic          i_m_ready;
  logic [PW-1:0] o_m_pixels;
  logic [WW-1:0] o_m_weights;
  logic [UW-1:0] o_m_user;
  logic          o_m_last;

  integer seed = 32'h90d8_5140;
  bit     outputs_done;

  // stimulus and expected beats of all images in order.
  logic [WW-1:0] w_data_q[$];
  logic          w_last_q[$];
  logic [PW-1:0] pix_q[$];
  logic          pix_last_q[$];
  logic [PW-1:0] exp_pix_q[$];
  logic [WW-1:0] exp_w_q[$];
  logic [UW-1:0] exp_user_q[$];
  logic          exp_last_q[$];

  conv_in_pipe #(
    .WORD_WIDTH(WORD_WIDTH), .UNITS(UNITS), .CORES(CORES), .KW_MAX(KW_MAX),
    .KH_MAX(KH_MAX), .CIN_MAX(CIN_MAX)
  ) uut (
    .aclk(aclk), .i_reset(i_reset),
    .i_s_pixels_valid(i_s_pixels_valid), .o_s_pixels_ready(o_s_pixels_ready),
    .i_s_pixels_data(i_s_pixels_data), .i_s_pixels_last(i_s_pixels_last),
    .i_s_weights_valid(i_s_weights_valid), .o_s_weights_ready(o_s_weights_ready),
    .i_s_weights_data(i_s_weights_data), .i_s_weights_last(i_s_weights_last),
    .o_m_valid(o_m_valid), .i_m_ready(i_m_ready), .o_m_pixels(o_m_pixels),
    .o_m_weights(o_m_weights), .o_m_user(o_m_user), .o_m_last(o_m_last)
  );

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  function automatic int rand_below(input int n);
    int v;
    v = $random(seed);
    return (v & 32'h7fff_ffff) % n;
  endfunction

  function automatic logic [63:0] rand_wide();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
      stop_with_failure();
    end
  endtask

  // reference model for one image with its stimulus beats.
  task automatic build_image(input bit one_row);
    int            kh_1;
    int            cin_1;
    int            cols_1;
    int            blocks_1;
    bit            is_max;
    logic [WW-1:0] cfg;
    logic [WW-1:0] w [KH_MAX*CIN_MAX];
    logic [63:0]   rnd;
    logic [UW-1:0] u;
    kh_1 = one_row ? 0 : 1 + rand_below(KH_MAX - 1);
    cin_1 = rand_below(CIN_MAX);
    cols_1 = rand_below(4);
    blocks_1 = rand_below(3);
    is_max = rand_below(2) == 1;
    cfg = '0;
    cfg[conv_in_pkg::CFG_KH_LSB +: KHB] = KHB'(kh_1);
    cfg[conv_in_pkg::CFG_CIN_LSB +: CINB] = CINB'(cin_1);
    cfg[conv_in_pkg::CFG_COLS_LSB +: COLB] = COLB'(cols_1);
    cfg[conv_in_pkg::CFG_BLOCKS_LSB +: BLKB] = BLKB'(blocks_1);
    cfg[conv_in_pkg::CFG_IS_MAX_BIT] = is_max;
    w_data_q.push_back(cfg);
    w_last_q.push_back(1'b0);
    for (int c = 0; c <= cin_1; c++) begin
      for (int r = 0; r <= kh_1; r++) begin
        rnd = rand_wide();
        w[c * (kh_1 + 1) + r] = rnd[WW-1:0];
        w_data_q.push_back(rnd[WW-1:0]);
        w_last_q.push_back(c == cin_1 && r == kh_1);
      end
    end
    for (int b = 0; b <= blocks_1; b++) begin
      for (int x = 0; x <= cols_1; x++) begin
        for (int c = 0; c <= cin_1; c++) begin
          rnd = rand_wide();
          pix_q.push_back(rnd[PW-1:0]);
          pix_last_q.push_back(b == blocks_1 && x == cols_1 && c == cin_1);
          // one beat per kernel row with the same pixels.
          for (int r = 0; r <= kh_1; r++) begin
            u = '0;
            u[conv_in_pkg::I_IS_MAX] = is_max;
            u[conv_in_pkg::I_IS_1X1] = kh_1 == 0;
            u[conv_in_pkg::I_IS_TOP_BLOCK] = b == 0;
            u[conv_in_pkg::I_IS_BOTTOM_BLOCK] = b == blocks_1;
            u[conv_in_pkg::I_IS_CIN_LAST] = c == cin_1;
            u[conv_in_pkg::I_KERNEL_ROW +: KHB] = KHB'(r);
            exp_pix_q.push_back(rnd[PW-1:0]);
            exp_w_q.push_back(w[c * (kh_1 + 1) + r]);
            exp_user_q.push_back(u);
            exp_last_q.push_back(b == blocks_1 && x == cols_1 && c == cin_1 && r == kh_1);
          end
        end
      end
    end
  endtask

  task automatic send_weights();
    int gap;
    int waited;
    for (int i = 0; i < w_data_q.size(); i++) begin
      gap = (rand_below(4) == 0) ? 1 + rand_below(3) : 0;
      repeat (gap) begin
        @(negedge aclk);
        i_s_weights_valid = 1'b0;
      end
      @(negedge aclk);
      i_s_weights_valid = 1'b1;
      i_s_weights_data = w_data_q[i];
      i_s_weights_last = w_last_q[i];
      waited = 0;
      do begin
        @(posedge aclk);
        waited++;
        if (waited > TIMEOUT) begin
          $display("timeout: weights beat %0d was never accepted", i);
          stop_with_failure();
        end
      end while (!o_s_weights_ready);
    end
    @(negedge aclk);
    i_s_weights_valid = 1'b0;
  endtask

  task automatic send_pixels();
    int gap;
    int waited;
    for (int i = 0; i < pix_q.size(); i++) begin
      gap = (rand_below(4) == 0) ? 1 + rand_below(3) : 0;
      repeat (gap) begin
        @(negedge aclk);
        i_s_pixels_valid = 1'b0;
      end
      @(negedge aclk);
      i_s_pixels_valid = 1'b1;
      i_s_pixels_data = pix_q[i];
      i_s_pixels_last = pix_last_q[i];
      waited = 0;
      do begin
        @(posedge aclk);
        waited++;
        if (waited > TIMEOUT) begin
          $display("timeout: pixel beat %0d was never accepted", i);
          stop_with_failure();
        end
      end while (!o_s_pixels_ready);
    end
    @(negedge aclk);
    i_s_pixels_valid = 1'b0;
  endtask

  task automatic collect_outputs();
    int waited;
    for (int i = 0; i < exp_pix_q.size(); i++) begin
      waited = 0;
      do begin
        @(posedge aclk);
        waited++;
        if (waited > TIMEOUT) begin
          $display("timeout: output beat %0d never arrived", i);
          stop_with_failure();
        end
      end while (!(o_m_valid && i_m_ready));
      check_value("o_m_pixels", 64'(o_m_pixels), 64'(exp_pix_q[i]));
      check_value("o_m_weights", 64'(o_m_weights), 64'(exp_w_q[i]));
      check_value("o_m_user", 64'(o_m_user), 64'(exp_user_q[i]));
      check_value("o_m_last", 64'(o_m_last), 64'(exp_last_q[i]));
    end
    outputs_done = 1'b1;
  endtask

  // random back-pressure until every beat is in.
  task automatic drive_m_ready();
    while (!outputs_done) begin
      @(negedge aclk);
      i_m_ready = rand_below(4) != 0;
    end
    i_m_ready = 1'b1;
  endtask

  initial begin
    i_reset = 1'b1;
    i_s_pixels_valid = 1'b0;
    i_s_pixels_data = '0;
    i_s_pixels_last = 1'b0;
    i_s_weights_valid = 1'b0;
    i_s_weights_data = '0;
    i_s_weights_last = 1'b0;
    i_m_ready = 1'b0;
    outputs_done = 1'b0;
    // middle image is the 1x1 case.
    for (int n = 0; n < NUM_IMAGES; n++) build_image(n == 1);
    repeat (10) @(posedge aclk);
    @(negedge aclk);
    i_reset = 1'b0;
    check_value("o_m_valid", 64'(o_m_valid), 64'd0);
    check_value("o_s_weights_ready", 64'(o_s_weights_ready), 64'd1);
    fork
      send_weights();
      send_pixels();
      collect_outputs();
      drive_m_ready();
    join
    // nothing may follow the final beat.
    repeat (20) begin
      @(posedge aclk);
      check_value("o_m_valid", 64'(o_m_valid), 64'd0);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- vlog.f
src/conv_in_pkg.sv
src/axis_skid.sv
src/weights_config_decoder.sv
src/weights_store.sv
src/conv_in_sequencer.sv
src/conv_in_pipe.sv
tests/conv_in_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench, then look for the pass line in the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
  --top-module conv_in_pipe_tb -o conv_in_pipe_sim \
  && ./obj_dir/conv_in_pipe_sim > sim.log 2>&1
grep -q "SIMULATION PASSED" sim.log \
  && echo "run passed" \
  || { echo "run failed, see sim.log"; exit 1; }
